// ==== bench/imu_patterns.txt ====
// Nine config writes, one per line: device register data (hex)
// Then three frames of two lines: regs 50..55 (accel), then regs 29..34 (gyro)
53 2D 00
53 2D 16
53 2D 08
53 31 08
53 2C 08
68 3E 00
68 15 FF
68 16 1E
68 17 00
// Frame register contents
34 12 CE FF 05 01
02 10 FE 80 7F 33
A5 5A 00 80 FF 7F
81 00 C3 3C 00 01
10 20 30 40 50 60
EF BE AD DE 0D F0

// ==== vlog.f ====
hw/imuBusPkg.sv
hw/imuRegMapPkg.sv
hw/i2cXferIf.sv
hw/imuSequencer.sv
hw/imuCommandRom.sv
hw/i2cByteEngine.sv
hw/axisAssembler.sv
hw/imuInterface.sv
bench/sensorModel.sv
bench/imuInterface_checker.sv
bench/imuInterface_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the IMU reader testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f vlog.f --top-module imuInterface_tb

output=$(./obj_dir/VimuInterface_tb)
echo "$output"
echo "$output" | grep -qx "RESULT: PASS"

// ==== bench/imuInterface_tb.sv ====
// Testbench for the IMU reader with an I2C sensor model, pattern-driven
// register contents and checks of config writes, frame reads and axes
`timescale 1ns/10ps
`default_nettype none

module imuInterface_tb;

    localparam int CLOCK_NS      = 4;
    localparam int CONFIG_WRITES = 9;
    localparam int FRAME_BYTES   = 12;
    localparam int PAT_FRAMES    = 3;
    localparam int FRAMES        = 4;                       // Last one from the LCG
    localparam int FRAME_BASE    = CONFIG_WRITES * 3;
    localparam int BIT_NS        = 4 * imuBusPkg::QUARTER_CLOCKS * CLOCK_NS;
    localparam int CONFIG_BITS   = imuBusPkg::IDLE_BITS + CONFIG_WRITES * 30;
    localparam int FRAME_BITS    = FRAME_BYTES * 41 + imuBusPkg::IDLE_BITS;
    localparam longint WATCHDOG_NS = 13 * (CONFIG_BITS + 5 * FRAME_BITS) * BIT_NS / 10;

    // Source register of each pattern column
    localparam logic [7:0] BYTE_REG [FRAME_BYTES] = '{8'd50, 8'd51, 8'd52, 8'd53,
        8'd54, 8'd55, 8'd29, 8'd30, 8'd31, 8'd32, 8'd33, 8'd34};
    // Register order of the reads within one frame
    localparam logic [7:0] READ_REG [FRAME_BYTES] = '{8'd50, 8'd51, 8'd52, 8'd53,
        8'd54, 8'd55, 8'd30, 8'd29, 8'd32, 8'd31, 8'd34, 8'd33};

    logic             CLOCK_50;
    logic             reset_n;
    logic             i2cSdaIn;
    logic             i2cScl;
    logic             i2cSdaOe;
    imuBusPkg::axis_t accelX;
    imuBusPkg::axis_t accelY;
    imuBusPkg::axis_t accelZ;
    imuBusPkg::axis_t gyroX;
    imuBusPkg::axis_t gyroY;
    imuBusPkg::axis_t gyroZ;
    logic             dataValid;

    logic [7:0]  patMem [FRAME_BASE + PAT_FRAMES * FRAME_BYTES];
    logic [7:0]  frameData [FRAME_BYTES];
    int          errors = 0;
    int          checks = 0;
    int unsigned lcgState = 25161;

    imuInterface u_dut (
        .CLOCK_50  (CLOCK_50),
        .reset_n   (reset_n),
        .i2cSdaIn  (i2cSdaIn),
        .i2cScl    (i2cScl),
        .i2cSdaOe  (i2cSdaOe),
        .accelX    (accelX),
        .accelY    (accelY),
        .accelZ    (accelZ),
        .gyroX     (gyroX),
        .gyroY     (gyroY),
        .gyroZ     (gyroZ),
        .dataValid (dataValid)
    );

    sensorModel u_model (
        .CLOCK_50 (CLOCK_50),
        .scl      (i2cScl),
        .sdaOe    (i2cSdaOe),
        .sda      (i2cSdaIn)
    );

    function automatic logic [7:0] nextRandom();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState[23:16];
    endfunction

    task automatic expectEqual(input string what, input logic [15:0] got,
                               input logic [15:0] exp);
        checks++;
        assert (got == exp)
        else
        begin
            errors++;
            $display("Mismatch at time %0t: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Fills the sensor registers for the next frame
    task automatic loadFrame(input int f);
        int dev;
        for (int i = 0; i < FRAME_BYTES; i++)
        begin
            dev = (i < 6) ? 0 : 1;
            if (f < PAT_FRAMES)
                frameData[i] = patMem[FRAME_BASE + f * FRAME_BYTES + i];
            else
                frameData[i] = nextRandom();
            u_model.regFile[dev][BYTE_REG[i]] = frameData[i];
        end
    endtask

    task automatic compareAxes();
        expectEqual("accelX", accelX, {frameData[1], frameData[0]});    // Little-endian
        expectEqual("accelY", accelY, {frameData[3], frameData[2]});
        expectEqual("accelZ", accelZ, {frameData[5], frameData[4]});
        expectEqual("gyroX", gyroX, {frameData[6], frameData[7]});      // Big-endian
        expectEqual("gyroY", gyroY, {frameData[8], frameData[9]});
        expectEqual("gyroZ", gyroZ, {frameData[10], frameData[11]});
    endtask

    task automatic verifyFrameReads(input int f);
        int base;
        base = f * FRAME_BYTES;
        expectEqual("read count", u_model.rdCount, base + FRAME_BYTES);
        expectEqual("write count", u_model.wrCount, CONFIG_WRITES);   // No writes after config
        for (int i = 0; i < FRAME_BYTES; i++)
        begin
            expectEqual("read device", u_model.rdDev[base + i], (i < 6) ? 8'h53 : 8'h68);
            expectEqual("read register", u_model.rdReg[base + i], READ_REG[i]);
            expectEqual("repeated start", u_model.rdRepeated[base + i], 1);
        end
    endtask

    task automatic verifyConfigWrites();
        for (int i = 0; i < CONFIG_WRITES; i++)
        begin
            expectEqual("write device", u_model.wrDev[i], patMem[3 * i]);
            expectEqual("write register", u_model.wrReg[i], patMem[3 * i + 1]);
            expectEqual("write data", u_model.wrData[i], patMem[3 * i + 2]);
        end
    endtask

    task automatic waitForValid(input logic level);
        while (dataValid !== level)
            @(negedge CLOCK_50);
    endtask

    // Axes keep the previous frame until the new one is committed whole
    task automatic watchHeldAxes(input logic [95:0] held);
        logic changed;
        changed = 1'b0;
        while (dataValid !== 1'b1)
        begin
            if ({accelX, accelY, accelZ, gyroX, gyroY, gyroZ} !== held)
                changed = 1'b1;
            @(negedge CLOCK_50);
        end
        checks++;
        assert (!changed)
        else
        begin
            errors++;
            $display("Mismatch at time %0t: axes changed before the frame was complete",
                     $time);
        end
    endtask

    task automatic finishRun(input logic timedOut);
        $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timedOut);
        if (errors == 0 && !timedOut)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    endtask

    initial
    begin
        CLOCK_50 = 1'b0;
        forever #(CLOCK_NS / 2) CLOCK_50 = ~CLOCK_50;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout at time %0t: the frames did not complete in time", $time);
        finishRun(1'b1);
    end

    initial
    begin
        logic [95:0] held;
        reset_n = 1'b0;
        $readmemh("bench/imu_patterns.txt", patMem);
        loadFrame(0);
        repeat (8) @(negedge CLOCK_50);
        reset_n = 1'b1;
        @(negedge CLOCK_50);
        expectEqual("SCL after reset", i2cScl, 1);
        expectEqual("SDA drive after reset", i2cSdaOe, 0);
        expectEqual("dataValid after reset", dataValid, 0);
        for (int f = 0; f < FRAMES; f++)
        begin
            if (f == 0)
                waitForValid(1'b1);
            else
                watchHeldAxes(held);
            verifyFrameReads(f);
            compareAxes();
            if (f == 0)
                verifyConfigWrites();
            held = {accelX, accelY, accelZ, gyroX, gyroY, gyroZ};
            if (f + 1 < FRAMES)
            begin
                loadFrame(f + 1);
                waitForValid(1'b0);
                // Falls as the next frame starts and before any of its reads finish
                expectEqual("reads at frame start", u_model.rdCount, (f + 1) * FRAME_BYTES);
            end
        end
        finishRun(1'b0);
    end

endmodule

`default_nettype wire

// ==== bench/imuInterface_checker.sv ====
// Bound assertions on the IMU reader ports: reset values, SCL and SDA edges, held axes
`timescale 1ns/10ps
`default_nettype none

module imuInterface_checker (
    input logic        CLOCK_50,
    input logic        reset_n,
    input logic        i2cScl,
    input logic        i2cSdaOe,
    input logic        dataValid,
    input logic [95:0] axes
);

    // Reset is synchronous, values show one clock after it is sampled
    resetValues: assert property (@(posedge CLOCK_50)
        !reset_n |=> (i2cScl && !i2cSdaOe && !dataValid))
        else $error("Bus or dataValid not at its reset value during reset");

    sclSdaApart: assert property (@(posedge CLOCK_50) disable iff (!reset_n)
        !((i2cScl != $past(i2cScl)) && (i2cSdaOe != $past(i2cSdaOe))))
        else $error("SCL and the SDA drive changed in the same clock");

    axesHeld: assert property (@(posedge CLOCK_50) disable iff (!reset_n)
        (dataValid && $past(dataValid)) |-> (axes == $past(axes)))
        else $error("Axis outputs changed while dataValid stayed high");

endmodule

bind imuInterface imuInterface_checker u_checker (
    .CLOCK_50  (CLOCK_50),
    .reset_n   (reset_n),
    .i2cScl    (i2cScl),
    .i2cSdaOe  (i2cSdaOe),
    .dataValid (dataValid),
    .axes      ({accelX, accelY, accelZ, gyroX, gyroY, gyroZ})
);

`default_nettype wire

// ==== bench/sensorModel.sv ====
// Behavioral I2C slave for both sensors with per-device register files
// and logs of every register write and read
`timescale 1ns/10ps
`default_nettype none

module sensorModel (
    input  logic CLOCK_50,
    input  logic scl,
    input  logic sdaOe,     // Master pulls SDA low
    output logic sda        // Wired-AND bus level
);

    typedef enum logic [1:0] {Idle, Receive, Transmit} mode_t;

    logic [7:0] regFile    [2][256];     // Index 0 is the accelerometer and 1 the gyroscope
    logic [7:0] wrDev      [16];
    logic [7:0] wrReg      [16];
    logic [7:0] wrData     [16];
    int         wrCount = 0;
    logic [7:0] rdDev      [128];
    logic [7:0] rdReg      [128];
    logic       rdRepeated [128];
    int         rdCount = 0;

    mode_t      mode = Idle;
    logic       prevScl = 1'b1;
    logic       prevOe = 1'b0;
    logic       busy = 1'b0;
    logic       repeated = 1'b0;
    logic       slaveLow = 1'b0;
    logic       dev = 1'b0;
    int         bitIdx = 0;      // Counted on SCL falls with 8 as the ACK slot
    int         frameNo = 0;     // Frames since the last start
    logic [7:0] shiftIn = '0;
    logic [7:0] addrByte = '0;
    logic [7:0] regPtr = '0;
    logic [7:0] txByte = '0;

    initial sda = 1'b1;

    always @(negedge CLOCK_50)
    begin
        if (scl && prevScl && sdaOe && !prevOe)
        begin
            repeated = busy;                // Start without a stop before it
            busy     = 1'b1;
            mode     = Receive;
            bitIdx   = -1;                  // The SCL fall that ends the start is no bit
            frameNo  = 0;
            slaveLow = 1'b0;
        end
        else if (scl && prevScl && !sdaOe && prevOe)
        begin
            busy     = 1'b0;                // Stop
            mode     = Idle;
            slaveLow = 1'b0;
        end
        else if (scl && !prevScl && mode == Receive && bitIdx < 8)
            shiftIn = {shiftIn[6:0], !sdaOe};
        else if (!scl && prevScl && mode == Receive)
        begin
            if (bitIdx == 7)
            begin
                if (frameNo == 0)
                begin
                    addrByte = shiftIn;
                    dev      = (shiftIn[7:1] == 7'h68);
                end
                else if (frameNo == 1)
                    regPtr = shiftIn;
                else if (wrCount < 16)
                begin
                    wrDev[wrCount]  = {1'b0, addrByte[7:1]};
                    wrReg[wrCount]  = regPtr;
                    wrData[wrCount] = shiftIn;
                    wrCount++;
                end
                bitIdx   = 8;
                slaveLow = 1'b1;            // ACK
            end
            else if (bitIdx == 8)
            begin
                slaveLow = 1'b0;
                bitIdx   = 0;
                if (frameNo == 0 && addrByte[0])
                begin
                    mode   = Transmit;
                    txByte = regFile[dev][regPtr];
                    if (rdCount < 128)
                    begin
                        rdDev[rdCount]      = {1'b0, addrByte[7:1]};
                        rdReg[rdCount]      = regPtr;
                        rdRepeated[rdCount] = repeated;
                        rdCount++;
                    end
                    slaveLow = !txByte[7];
                end
                frameNo++;
            end
            else
                bitIdx++;
        end
        else if (!scl && prevScl && mode == Transmit)
        begin
            if (bitIdx < 7)
            begin
                bitIdx++;
                slaveLow = !txByte[7 - bitIdx];
            end
            else if (bitIdx == 7)
            begin
                bitIdx   = 8;
                slaveLow = 1'b0;            // Master ACK or NACK slot
            end
            else
                mode = Idle;
        end
        prevScl = scl;
        prevOe  = sdaOe;
        sda     = !(sdaOe || slaveLow);
    end

endmodule

`default_nettype wire

// ==== hw/imuInterface.sv ====
// IMU reader top level, joins the sequencer, command table, I2C engine and assembler
`timescale 1ns/10ps
`default_nettype none

module imuInterface (
    input  logic             CLOCK_50,
    input  logic             reset_n,
    input  logic             i2cSdaIn,
    output logic             i2cScl,
    output logic             i2cSdaOe,     // Board wrapper pulls SDA low when set
    output imuBusPkg::axis_t accelX,
    output imuBusPkg::axis_t accelY,
    output imuBusPkg::axis_t accelZ,
    output imuBusPkg::axis_t gyroX,
    output imuBusPkg::axis_t gyroY,
    output imuBusPkg::axis_t gyroZ,
    output logic             dataValid
);

    imuRegMapPkg::step_t step;
    imuBusPkg::devAddr_t devAddr;
    imuBusPkg::regAddr_t regAddr;
    logic                isRead;
    imuBusPkg::byte_t    writeData;
    logic                byteStrobe;
    logic                frameStart;
    logic                frameDone;

    i2cXferIf xferBus ();

    imuSequencer u_sequencer (
        .CLOCK_50   (CLOCK_50),
        .reset_n    (reset_n),
        .xfer       (xferBus.master),
        .step       (step),
        .devAddr    (devAddr),
        .regAddr    (regAddr),
        .isRead     (isRead),
        .writeData  (writeData),
        .byteStrobe (byteStrobe),
        .frameStart (frameStart),
        .frameDone  (frameDone)
    );

    imuCommandRom u_commandRom (
        .step      (step),
        .devAddr   (devAddr),
        .regAddr   (regAddr),
        .isRead    (isRead),
        .writeData (writeData)
    );

    i2cByteEngine u_byteEngine (
        .CLOCK_50 (CLOCK_50),
        .reset_n  (reset_n),
        .i2cSdaIn (i2cSdaIn),
        .xfer     (xferBus.engine),
        .i2cScl   (i2cScl),
        .i2cSdaOe (i2cSdaOe)
    );

    axisAssembler u_assembler (
        .CLOCK_50   (CLOCK_50),
        .reset_n    (reset_n),
        .byteStrobe (byteStrobe),
        .frameStart (frameStart),
        .frameDone  (frameDone),
        .step       (step),
        .readData   (xferBus.readData),
        .accelX     (accelX),
        .accelY     (accelY),
        .accelZ     (accelZ),
        .gyroX      (gyroX),
        .gyroY      (gyroY),
        .gyroZ      (gyroZ),
        .dataValid  (dataValid)
    );

endmodule

`default_nettype wire

// ==== hw/axisAssembler.sv ====
// Frame byte staging, six-axis commit and the dataValid flag
`timescale 1ns/10ps
`default_nettype none

module axisAssembler (
    input  logic                CLOCK_50,
    input  logic                reset_n,
    input  logic                byteStrobe,
    input  logic                frameStart,
    input  logic                frameDone,
    input  imuRegMapPkg::step_t step,
    input  imuBusPkg::byte_t    readData,
    output imuBusPkg::axis_t    accelX,
    output imuBusPkg::axis_t    accelY,
    output imuBusPkg::axis_t    accelZ,
    output imuBusPkg::axis_t    gyroX,
    output imuBusPkg::axis_t    gyroY,
    output imuBusPkg::axis_t    gyroZ,
    output logic                dataValid
);

    imuRegMapPkg::step_t readIdx;
    imuBusPkg::byte_t    stage  [imuRegMapPkg::READ_STEPS];
    imuBusPkg::byte_t    merged [imuRegMapPkg::READ_STEPS];
    imuBusPkg::axis_t    words  [imuRegMapPkg::READ_STEPS / 5'd2];

    assign readIdx = step - imuRegMapPkg::CONFIG_STEPS;

    always_ff @(posedge CLOCK_50)
    begin
        if (byteStrobe)
            stage[readIdx[3:0]] <= readData;
    end

    // Last byte of the frame arrives together with frameDone
    always_comb
    begin
        for (int i = 0; i < imuRegMapPkg::READ_STEPS; i++)
            merged[i] = (byteStrobe && readIdx == i) ? readData : stage[i];
    end

    // Read order puts every low byte at an even index, for both sensors
    always_ff @(posedge CLOCK_50)
    begin
        if (!reset_n)
        begin
            for (int k = 0; k < imuRegMapPkg::READ_STEPS / 2; k++)
                words[k] <= '0;
            dataValid <= 1'b0;
        end
        else if (frameDone)
        begin
            for (int k = 0; k < imuRegMapPkg::READ_STEPS / 2; k++)
                words[k] <= {merged[2*k+1], merged[2*k]};
            dataValid <= 1'b1;
        end
        else if (frameStart)
            dataValid <= 1'b0;      // New frame under way
    end

    assign accelX = words[0];
    assign accelY = words[1];
    assign accelZ = words[2];
    assign gyroX  = words[3];
    assign gyroY  = words[4];
    assign gyroZ  = words[5];

endmodule

`default_nettype wire

// ==== hw/i2cByteEngine.sv ====
// Bit-level I2C master for one register write, or one read with repeated start
`timescale 1ns/10ps
`default_nettype none

module i2cByteEngine (
    input  logic     CLOCK_50,
    input  logic     reset_n,
    input  logic     i2cSdaIn,
    i2cXferIf.engine xfer,
    output logic     i2cScl,
    output logic     i2cSdaOe
);

    typedef enum logic [3:0] {
        BusIdle, StartCond, AddrWr, RegSel, DataWr,
        RepSetup, RepStart, AddrRd, DataRd, StopCond
    } phase_t;

    phase_t             phase;
    imuBusPkg::divCnt_t divCnt;      // Clocks within a quarter
    logic [1:0]         quarter;
    logic [3:0]         bitCnt;      // Bit within a 9-bit frame, 8 is the ACK slot
    imuBusPkg::byte_t   shiftReg;
    imuBusPkg::byte_t   frameByte;
    logic               inFrame;
    logic               txFrame;
    logic               txBit;
    logic               quarterStart;
    logic               quarterEnd;
    logic               slotEnd;
    logic               frameLast;

    assign quarterStart = (divCnt == '0);
    assign quarterEnd   = (divCnt == imuBusPkg::QUARTER_LAST);
    assign slotEnd      = quarterEnd && (quarter == 2'd3);
    assign frameLast    = (bitCnt == 4'd8);
    assign txBit        = (bitCnt == 4'd0) ? frameByte[7] : shiftReg[7];

    always_comb
    begin
        frameByte = 8'hFF;      // Released bus while receiving
        inFrame   = 1'b1;
        case (phase)
            AddrWr:  frameByte = {xfer.devAddr, 1'b0};
            RegSel:  frameByte = xfer.regAddr;
            DataWr:  frameByte = xfer.writeData;
            AddrRd:  frameByte = {xfer.devAddr, 1'b1};
            DataRd:  frameByte = 8'hFF;
            default: inFrame   = 1'b0;
        endcase
        txFrame = inFrame && (phase != DataRd);
    end

    assign xfer.done     = (phase == StopCond) && slotEnd;
    assign xfer.readData = shiftReg;

    // Quarter 0 moves SDA, 1 raises SCL, 2 samples, 3 drops SCL
    always_ff @(posedge CLOCK_50)
    begin
        if (!reset_n)
        begin
            phase    <= BusIdle;
            divCnt   <= '0;
            quarter  <= '0;
            bitCnt   <= '0;
            i2cScl   <= 1'b1;
            i2cSdaOe <= 1'b0;
        end
        else if (phase == BusIdle)
        begin
            divCnt  <= '0;
            quarter <= '0;
            bitCnt  <= '0;
            if (xfer.start)
                phase <= StartCond;
        end
        else
        begin
            divCnt <= quarterEnd ? '0 : divCnt + 1'b1;
            if (quarterEnd)
                quarter <= quarter + 2'd1;

            if (quarterStart)
            begin
                case (quarter)
                    2'd0:
                        if (phase == RepSetup)
                            i2cSdaOe <= 1'b0;           // Let SDA rise before repeated start
                        else if (phase == StopCond)
                            i2cSdaOe <= 1'b1;
                        else if (inFrame)
                            i2cSdaOe <= txFrame && !frameLast && !txBit;
                    2'd1:
                        if (phase != StartCond && phase != RepStart)
                            i2cScl <= 1'b1;
                    2'd2:
                        if (phase == StartCond || phase == RepStart)
                            i2cSdaOe <= 1'b1;           // SDA falls with SCL high
                        else if (phase == StopCond)
                            i2cSdaOe <= 1'b0;           // SDA rises with SCL high
                    default:
                        if (phase != RepSetup && phase != StopCond)
                            i2cScl <= 1'b0;
                endcase
            end

            if (slotEnd)
            begin
                case (phase)
                    StartCond: phase <= AddrWr;
                    RepSetup:  phase <= RepStart;
                    RepStart:  phase <= AddrRd;
                    StopCond:  phase <= BusIdle;
                    default:
                    begin
                        bitCnt <= frameLast ? 4'd0 : bitCnt + 4'd1;
                        if (frameLast)
                        begin
                            case (phase)
                                AddrWr:  phase <= RegSel;
                                RegSel:  phase <= xfer.isRead ? RepSetup : DataWr;
                                AddrRd:  phase <= DataRd;
                                default: phase <= StopCond;
                            endcase
                        end
                    end
                endcase
            end
        end
    end

    // Load at the first bit of a frame, shift at each data sample
    always_ff @(posedge CLOCK_50)
    begin
        if (inFrame && quarterStart)
        begin
            if (quarter == 2'd0 && bitCnt == 4'd0)
                shiftReg <= frameByte;
            else if (quarter == 2'd2 && !frameLast)
                shiftReg <= {shiftReg[6:0], i2cSdaIn};
        end
    end

endmodule

`default_nettype wire

// ==== hw/imuCommandRom.sv ====
// Step-indexed command table with the config writes and the axis register reads
`timescale 1ns/10ps
`default_nettype none

module imuCommandRom (
    input  imuRegMapPkg::step_t step,
    output imuBusPkg::devAddr_t devAddr,
    output imuBusPkg::regAddr_t regAddr,
    output logic                isRead,
    output imuBusPkg::byte_t    writeData
);

    imuRegMapPkg::step_t readIdx;
    imuRegMapPkg::step_t gyroIdx;

    assign readIdx = step - imuRegMapPkg::CONFIG_STEPS;
    assign gyroIdx = readIdx - (imuRegMapPkg::READ_STEPS / 5'd2);

    always_comb
    begin
        devAddr   = imuRegMapPkg::ACCEL_ADDR;
        regAddr   = imuRegMapPkg::CONFIG_REG[step[3:0]];
        isRead    = 1'b0;
        writeData = imuRegMapPkg::CONFIG_DATA[step[3:0]];
        if (step < imuRegMapPkg::CONFIG_STEPS)
        begin
            if (step >= imuRegMapPkg::ACCEL_CONFIG_STEPS)
                devAddr = imuRegMapPkg::GYRO_ADDR;
        end
        else if (readIdx < imuRegMapPkg::READ_STEPS / 5'd2)
        begin
            isRead    = 1'b1;
            regAddr   = imuRegMapPkg::ACCEL_DATAX0 + {3'b000, readIdx};   // 50..55 in order
            writeData = '0;
        end
        else
        begin
            // Gyro pairs are fetched low register first, 30 29 32 31 34 33
            devAddr   = imuRegMapPkg::GYRO_ADDR;
            isRead    = 1'b1;
            regAddr   = imuRegMapPkg::GYRO_XOUT_H + {3'b000, gyroIdx ^ 5'd1};
            writeData = '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/imuSequencer.sv ====
// Control FSM for the idle wait, one-time configuration and repeated frame reads
`timescale 1ns/10ps
`default_nettype none

module imuSequencer (
    input  logic                CLOCK_50,
    input  logic                reset_n,
    i2cXferIf.master            xfer,
    output imuRegMapPkg::step_t step,
    input  imuBusPkg::devAddr_t devAddr,
    input  imuBusPkg::regAddr_t regAddr,
    input  logic                isRead,
    input  imuBusPkg::byte_t    writeData,
    output logic                byteStrobe,
    output logic                frameStart,
    output logic                frameDone
);

    imuRegMapPkg::seqState_t seqState;
    imuBusPkg::idleCnt_t     idleCnt;
    logic                    startPulse;

    // Table entry for the current step goes straight to the engine
    // Step only moves on done, so the fields hold during a transaction
    assign xfer.start     = startPulse;
    assign xfer.devAddr   = devAddr;
    assign xfer.regAddr   = regAddr;
    assign xfer.isRead    = isRead;
    assign xfer.writeData = writeData;

    assign byteStrobe = (seqState == imuRegMapPkg::ReadFrame) && xfer.done;
    assign frameStart = startPulse && (step == imuRegMapPkg::CONFIG_STEPS);  // First read of a frame
    assign frameDone  = byteStrobe && (step == imuRegMapPkg::LAST_STEP);

    always_ff @(posedge CLOCK_50)
    begin
        if (!reset_n)
        begin
            seqState   <= imuRegMapPkg::IdleWait;
            step       <= '0;
            idleCnt    <= '0;
            startPulse <= 1'b0;
        end
        else
        begin
            startPulse <= 1'b0;
            case (seqState)
                imuRegMapPkg::IdleWait:
                begin
                    if (idleCnt == imuBusPkg::IDLE_LAST)
                    begin
                        idleCnt    <= '0;
                        startPulse <= 1'b1;
                        // Step is still zero only after the wait that follows reset
                        seqState   <= (step == '0) ? imuRegMapPkg::Configure
                                                   : imuRegMapPkg::ReadFrame;
                    end
                    else
                        idleCnt <= idleCnt + 1'b1;
                end
                imuRegMapPkg::Configure:
                begin
                    if (xfer.done)
                    begin
                        step       <= step + 1'b1;
                        startPulse <= 1'b1;
                        if (step == imuRegMapPkg::CONFIG_STEPS - 5'd1)
                            seqState <= imuRegMapPkg::ReadFrame;   // No wait before the first frame
                    end
                end
                default:
                begin
                    if (xfer.done)
                    begin
                        if (step == imuRegMapPkg::LAST_STEP)
                        begin
                            step     <= imuRegMapPkg::CONFIG_STEPS;
                            seqState <= imuRegMapPkg::IdleWait;
                        end
                        else
                        begin
                            step       <= step + 1'b1;
                            startPulse <= 1'b1;
                        end
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== hw/i2cXferIf.sv ====
// Register transaction link between the sequencer and the I2C byte engine
`timescale 1ns/10ps
`default_nettype none

interface i2cXferIf;

    logic                start;      // One-cycle request, only while the engine is idle
    imuBusPkg::devAddr_t devAddr;
    imuBusPkg::regAddr_t regAddr;
    logic                isRead;
    imuBusPkg::byte_t    writeData;
    logic                done;       // One pulse per start
    imuBusPkg::byte_t    readData;   // Valid with done

    modport master (
        output start, devAddr, regAddr, isRead, writeData,
        input  done, readData
    );

    modport engine (
        input  start, devAddr, regAddr, isRead, writeData,
        output done, readData
    );

endinterface

`default_nettype wire

// ==== hw/imuRegMapPkg.sv ====
// Sensor addresses, register map, configuration table and sequencer state type
`default_nettype none

package imuRegMapPkg;

    typedef logic [4:0] step_t;
    typedef enum logic [1:0] {IdleWait, Configure, ReadFrame} seqState_t;

    localparam imuBusPkg::devAddr_t ACCEL_ADDR = 7'h53;    // ADXL345 with ALT pin low
    localparam imuBusPkg::devAddr_t GYRO_ADDR  = 7'h68;

    localparam step_t CONFIG_STEPS       = 5'd9;
    localparam step_t READ_STEPS         = 5'd12;
    localparam step_t LAST_STEP          = CONFIG_STEPS + READ_STEPS - 5'd1;
    localparam step_t ACCEL_CONFIG_STEPS = 5'd5;           // First five writes go to the accelerometer

    // Config writes in issue order
    // Accel: POWER_CTL three times, DATA_FORMAT, BW_RATE
    // Gyro: PWR_MGM, SMPLRT_DIV, DLPF_FS, INT_CFG
    localparam imuBusPkg::regAddr_t CONFIG_REG [CONFIG_STEPS] =
        '{8'h2D, 8'h2D, 8'h2D, 8'h31, 8'h2C, 8'd62, 8'd21, 8'd22, 8'd23};
    localparam imuBusPkg::byte_t CONFIG_DATA [CONFIG_STEPS] =
        '{8'h00, 8'h16, 8'h08, 8'h08, 8'h08, 8'h00, 8'hFF, 8'h1E, 8'h00};

    localparam imuBusPkg::regAddr_t ACCEL_DATAX0 = 8'd50;  // DATAX0..DATAZ1, low byte first
    localparam imuBusPkg::regAddr_t GYRO_XOUT_H  = 8'd29;  // XOUT_H..ZOUT_L, high byte first

endpackage

`default_nettype wire

// ==== hw/imuBusPkg.sv ====
// I2C bus timing constants and the vector types shared by the bus and data paths
`default_nettype none

package imuBusPkg;

    localparam int QUARTER_CLOCKS = 32;     // 128 clocks per bit, about 390 kHz at 50 MHz
    localparam int IDLE_BITS      = 200;    // Bit times in the idle wait
    localparam int IDLE_CLOCKS    = IDLE_BITS * 4 * QUARTER_CLOCKS;

    typedef logic [6:0] devAddr_t;          // 7-bit I2C device address
    typedef logic [7:0] regAddr_t;          // Sensor register number
    typedef logic [7:0] byte_t;
    typedef logic signed [15:0] axis_t;     // One assembled axis sample

    // Counter types sized from the timing constants
    typedef logic [$clog2(QUARTER_CLOCKS)-1:0] divCnt_t;
    typedef logic [$clog2(IDLE_CLOCKS)-1:0]    idleCnt_t;

    localparam divCnt_t  QUARTER_LAST = divCnt_t'(QUARTER_CLOCKS - 1);
    localparam idleCnt_t IDLE_LAST    = idleCnt_t'(IDLE_CLOCKS - 1);

endpackage

`default_nettype wire
